// ==== rtl/wbuf_pkg.sv ====
//------------------------------------------------------------
// Write buffer package
// Directory and line sizes, payload types, entry states
// and configuration register selects
//------------------------------------------------------------
package wbuf_pkg;

    localparam int unsigned WBUF_ENTRIES      = 4;
    localparam int unsigned ADDR_WIDTH        = 32;
    localparam int unsigned WORD_WIDTH        = 32;
    localparam int unsigned LINE_WORDS        = 4;
    localparam int unsigned OFFSET_WIDTH      = 4;
    localparam int unsigned WORD_OFFSET_WIDTH = 2;
    localparam int unsigned TAG_WIDTH         = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int unsigned TIMECNT_WIDTH     = 8;
    localparam int unsigned ID_WIDTH          = 2;
    localparam int unsigned DEFAULT_THRESHOLD = 4;

    typedef logic [ADDR_WIDTH-1:0]              wbuf_addr_t;
    typedef logic [TAG_WIDTH-1:0]               wbuf_tag_t;
    typedef logic [WORD_WIDTH-1:0]              wbuf_word_t;
    typedef logic [WORD_WIDTH/8-1:0]            wbuf_word_be_t;
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0]   wbuf_line_t;
    typedef logic [LINE_WORDS*WORD_WIDTH/8-1:0] wbuf_line_be_t;
    typedef logic [ID_WIDTH-1:0]                wbuf_id_t;
    typedef logic [TIMECNT_WIDTH-1:0]           wbuf_timecnt_t;

    // Life cycle of a directory entry
    typedef enum logic [1:0] {
        WBUF_FREE = 2'b00,
        WBUF_OPEN = 2'b01,  // collecting writes, timer running
        WBUF_PEND = 2'b10,
        WBUF_SENT = 2'b11   // waits for the memory acknowledge
    } wbuf_state_e;

    // Configuration register select
    typedef enum logic {
        CFG_THRESHOLD = 1'b0,
        CFG_CTRL      = 1'b1
    } wbuf_cfg_reg_e;

endpackage

// ==== rtl/wbuf_cfg_regs.sv ====
//------------------------------------------------------------
// Write buffer configuration registers
// Timer threshold, reset-timer-on-write and
// inhibit-coalescing control bits
//------------------------------------------------------------
`timescale 1ns/1ps

module wbuf_cfg_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    cfg_valid_i,
    input  wbuf_pkg::wbuf_cfg_reg_e cfg_sel_i,
    input  wbuf_pkg::wbuf_timecnt_t cfg_wdata_i,
    output wbuf_pkg::wbuf_timecnt_t threshold_o,
    output logic                    reset_on_write_o,
    output logic                    inhibit_coalescing_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            threshold_o          <= wbuf_pkg::wbuf_timecnt_t'(wbuf_pkg::DEFAULT_THRESHOLD);
            reset_on_write_o     <= 1'b0;
            inhibit_coalescing_o <= 1'b0;
        end else if (cfg_valid_i) begin
            case (cfg_sel_i)
                wbuf_pkg::CFG_THRESHOLD: begin
                    threshold_o <= cfg_wdata_i;
                end
                wbuf_pkg::CFG_CTRL: begin
                    // Bit 0 restarts the timer, bit 1 blocks merging
                    reset_on_write_o     <= cfg_wdata_i[0];
                    inhibit_coalescing_o <= cfg_wdata_i[1];
                end
            endcase
        end
    end

endmodule

// ==== rtl/wbuf_dir.sv ====
//------------------------------------------------------------
// Write buffer directory
// Entry state, tag and timer per entry, write-hit and
// read-hit detection, free entry choice, empty/full flags
//------------------------------------------------------------
`timescale 1ns/1ps

module wbuf_dir (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              write_valid_i,
    output logic                              write_ready_o,
    input  wbuf_pkg::wbuf_addr_t              write_addr_i,
    input  logic                              flush_all_i,
    input  wbuf_pkg::wbuf_addr_t              read_addr_i,
    output logic                              read_hit_o,
    input  wbuf_pkg::wbuf_timecnt_t           threshold_i,
    input  logic                              reset_on_write_i,
    input  logic                              inhibit_coalescing_i,
    output logic                              store_we_o,
    output logic                              store_init_o,
    output wbuf_pkg::wbuf_id_t                store_id_o,
    output logic [wbuf_pkg::WBUF_ENTRIES-1:0] pend_o,
    input  logic                              send_fire_i,
    input  wbuf_pkg::wbuf_id_t                send_id_i,
    input  logic                              ack_valid_i,
    input  wbuf_pkg::wbuf_id_t                ack_id_i,
    input  wbuf_pkg::wbuf_id_t                head_id_i,
    output wbuf_pkg::wbuf_tag_t               head_tag_o,
    output logic                              empty_o,
    output logic                              full_o
);

    wbuf_pkg::wbuf_state_e             state_q [wbuf_pkg::WBUF_ENTRIES];
    wbuf_pkg::wbuf_tag_t               tag_q   [wbuf_pkg::WBUF_ENTRIES];
    wbuf_pkg::wbuf_timecnt_t           cnt_q   [wbuf_pkg::WBUF_ENTRIES];

    wbuf_pkg::wbuf_tag_t               write_tag;
    wbuf_pkg::wbuf_tag_t               read_tag;
    logic [wbuf_pkg::WBUF_ENTRIES-1:0] free_vec;
    logic [wbuf_pkg::WBUF_ENTRIES-1:0] read_hit_vec;
    logic [wbuf_pkg::WBUF_ENTRIES-1:0] timeout;
    logic [wbuf_pkg::WBUF_ENTRIES-1:0] restart;
    logic                              write_hit;
    wbuf_pkg::wbuf_id_t                hit_id;
    wbuf_pkg::wbuf_id_t                free_id;
    logic                              coalesce;
    logic                              alloc;
    logic                              new_pend;

    assign write_tag = write_addr_i[wbuf_pkg::ADDR_WIDTH-1:wbuf_pkg::OFFSET_WIDTH];
    assign read_tag  = read_addr_i[wbuf_pkg::ADDR_WIDTH-1:wbuf_pkg::OFFSET_WIDTH];

    // Descending scan so the lowest free entry wins
    always_comb begin
        write_hit = 1'b0;
        hit_id    = '0;
        free_id   = '0;
        for (int i = wbuf_pkg::WBUF_ENTRIES - 1; i >= 0; i--) begin
            free_vec[i]     = (state_q[i] == wbuf_pkg::WBUF_FREE);
            pend_o[i]       = (state_q[i] == wbuf_pkg::WBUF_PEND);
            read_hit_vec[i] = !free_vec[i] && (tag_q[i] == read_tag);
            timeout[i]      = (cnt_q[i] == threshold_i - 1'b1);
            if (free_vec[i]) begin
                free_id = wbuf_pkg::wbuf_id_t'(i);
            end
            // At most one open or pending entry per tag
            if ((state_q[i] == wbuf_pkg::WBUF_OPEN || pend_o[i]) && tag_q[i] == write_tag) begin
                write_hit = 1'b1;
                hit_id    = wbuf_pkg::wbuf_id_t'(i);
            end
        end
    end

    assign coalesce = write_valid_i && write_hit && !inhibit_coalescing_i;
    assign alloc    = write_valid_i && !write_hit && !full_o;
    assign new_pend = (threshold_i == '0) || flush_all_i || inhibit_coalescing_i;

    always_comb begin
        for (int i = 0; i < wbuf_pkg::WBUF_ENTRIES; i++) begin
            restart[i] = coalesce && reset_on_write_i && (hit_id == wbuf_pkg::wbuf_id_t'(i));
        end
    end

    assign write_ready_o = write_hit ? !inhibit_coalescing_i : !full_o;
    assign store_we_o    = coalesce || alloc;
    assign store_init_o  = alloc;
    assign store_id_o    = write_hit ? hit_id : free_id;

    assign read_hit_o = |read_hit_vec;
    assign empty_o    = &free_vec;
    assign full_o     = ~|free_vec;
    assign head_tag_o = tag_q[head_id_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < wbuf_pkg::WBUF_ENTRIES; i++) begin
                state_q[i] <= wbuf_pkg::WBUF_FREE;
                cnt_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < wbuf_pkg::WBUF_ENTRIES; i++) begin
                case (state_q[i])
                    wbuf_pkg::WBUF_FREE: begin
                        if (alloc && free_id == wbuf_pkg::wbuf_id_t'(i)) begin
                            state_q[i] <= new_pend ? wbuf_pkg::WBUF_PEND : wbuf_pkg::WBUF_OPEN;
                            cnt_q[i]   <= '0;
                        end
                    end
                    wbuf_pkg::WBUF_OPEN: begin
                        // A restarting write cancels this cycle's timeout
                        cnt_q[i] <= restart[i] ? '0 : cnt_q[i] + 1'b1;
                        if (flush_all_i || inhibit_coalescing_i
                                || (timeout[i] && !restart[i])) begin
                            state_q[i] <= wbuf_pkg::WBUF_PEND;
                        end
                    end
                    wbuf_pkg::WBUF_PEND: begin
                        if (send_fire_i && send_id_i == wbuf_pkg::wbuf_id_t'(i)) begin
                            state_q[i] <= wbuf_pkg::WBUF_SENT;
                        end
                    end
                    wbuf_pkg::WBUF_SENT: begin
                        if (ack_valid_i && ack_id_i == wbuf_pkg::wbuf_id_t'(i)) begin
                            state_q[i] <= wbuf_pkg::WBUF_FREE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_q[free_id] <= write_tag;
        end
    end

    // Memory only acknowledges lines it was sent
    ack_sent_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_valid_i |-> state_q[ack_id_i] == wbuf_pkg::WBUF_SENT)
        else $error("wbuf_dir: acknowledge names an entry that is not sent");

endmodule

// ==== rtl/wbuf_line_store.sv ====
//------------------------------------------------------------
// Write buffer line store
// One data line and byte-enable mask per directory entry,
// byte-merging word writes, read port for the send head
//------------------------------------------------------------
`timescale 1ns/1ps

module wbuf_line_store (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    we_i,
    input  logic                    init_i,
    input  wbuf_pkg::wbuf_id_t      id_i,
    input  logic [wbuf_pkg::OFFSET_WIDTH-wbuf_pkg::WORD_OFFSET_WIDTH-1:0] word_sel_i,
    input  wbuf_pkg::wbuf_word_t    data_i,
    input  wbuf_pkg::wbuf_word_be_t be_i,
    input  wbuf_pkg::wbuf_id_t      rd_id_i,
    output wbuf_pkg::wbuf_line_t    rd_data_o,
    output wbuf_pkg::wbuf_line_be_t rd_be_o
);

    localparam int unsigned WORD_BYTES = wbuf_pkg::WORD_WIDTH / 8;

    wbuf_pkg::wbuf_line_t    data_q [wbuf_pkg::WBUF_ENTRIES];
    wbuf_pkg::wbuf_line_be_t be_q   [wbuf_pkg::WBUF_ENTRIES];
    wbuf_pkg::wbuf_line_be_t wr_be;

    // Word enables moved to their place in the line
    assign wr_be = wbuf_pkg::wbuf_line_be_t'(be_i) << (word_sel_i * WORD_BYTES);

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (be_i[b]) begin
                    data_q[id_i][word_sel_i*wbuf_pkg::WORD_WIDTH + b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

    // A new entry starts with no valid bytes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < wbuf_pkg::WBUF_ENTRIES; i++) begin
                be_q[i] <= '0;
            end
        end else if (we_i) begin
            be_q[id_i] <= (init_i ? '0 : be_q[id_i]) | wr_be;
        end
    end

    assign rd_data_o = data_q[rd_id_i];
    assign rd_be_o   = be_q[rd_id_i];

endmodule

// ==== rtl/wbuf_send.sv ====
//------------------------------------------------------------
// Write buffer send path
// Round-robin choice among pending entries and the FIFO
// of entry ids waiting for the memory request channel
//------------------------------------------------------------
`timescale 1ns/1ps

module wbuf_send (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [wbuf_pkg::WBUF_ENTRIES-1:0] pend_i,
    output logic                              send_fire_o,
    output wbuf_pkg::wbuf_id_t                send_id_o,
    output logic                              req_valid_o,
    input  logic                              req_ready_i,
    output wbuf_pkg::wbuf_id_t                head_id_o
);

    wbuf_pkg::wbuf_id_t          rr_q;
    wbuf_pkg::wbuf_id_t          fifo_q [wbuf_pkg::WBUF_ENTRIES];
    wbuf_pkg::wbuf_id_t          wr_ptr_q;
    wbuf_pkg::wbuf_id_t          rd_ptr_q;
    logic [wbuf_pkg::ID_WIDTH:0] count_q;
    logic                        fifo_full;
    logic                        pop;

    // Search starts just after the last granted entry
    always_comb begin
        wbuf_pkg::wbuf_id_t idx;
        send_id_o = rr_q;
        for (int k = wbuf_pkg::WBUF_ENTRIES; k >= 1; k--) begin
            idx = wbuf_pkg::wbuf_id_t'(rr_q + k);
            if (pend_i[idx]) begin
                send_id_o = idx;
            end
        end
    end

    assign fifo_full   = (count_q == wbuf_pkg::WBUF_ENTRIES);
    assign send_fire_o = |pend_i && !fifo_full;
    assign req_valid_o = (count_q != '0);
    assign pop         = req_valid_o && req_ready_i;
    assign head_id_o   = fifo_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q     <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (send_fire_o) begin
                rr_q     <= send_id_o;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (send_fire_o && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !send_fire_o) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (send_fire_o) begin
            fifo_q[wr_ptr_q] <= send_id_o;
        end
    end

    // Ids in the FIFO belong to sent entries, so a full FIFO
    // leaves no pending entry that could be pushed
    no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        |pend_i |-> !fifo_full)
        else $error("wbuf_send: pending entry while the send FIFO is full");

endmodule

// ==== rtl/wbuf_top.sv ====
//------------------------------------------------------------
// Coalescing write buffer top level
// Connects configuration, directory, line store and send
// path, and forms the memory write request
//------------------------------------------------------------
`timescale 1ns/1ps

module wbuf_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    write_valid_i,
    output logic                    write_ready_o,
    input  wbuf_pkg::wbuf_addr_t    write_addr_i,
    input  wbuf_pkg::wbuf_word_t    write_data_i,
    input  wbuf_pkg::wbuf_word_be_t write_be_i,
    input  logic                    cfg_valid_i,
    input  wbuf_pkg::wbuf_cfg_reg_e cfg_sel_i,
    input  wbuf_pkg::wbuf_timecnt_t cfg_wdata_i,
    input  logic                    flush_all_i,
    input  wbuf_pkg::wbuf_addr_t    read_addr_i,
    output logic                    read_hit_o,
    output logic                    empty_o,
    output logic                    full_o,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output wbuf_pkg::wbuf_addr_t    mem_req_addr_o,
    output wbuf_pkg::wbuf_line_t    mem_req_data_o,
    output wbuf_pkg::wbuf_line_be_t mem_req_be_o,
    output wbuf_pkg::wbuf_id_t      mem_req_id_o,
    input  logic                    mem_ack_valid_i,
    input  wbuf_pkg::wbuf_id_t      mem_ack_id_i
);

    wbuf_pkg::wbuf_timecnt_t           threshold;
    logic                              reset_on_write;
    logic                              inhibit_coalescing;
    logic                              store_we;
    logic                              store_init;
    wbuf_pkg::wbuf_id_t                store_id;
    logic [wbuf_pkg::WBUF_ENTRIES-1:0] pend;
    logic                              send_fire;
    wbuf_pkg::wbuf_id_t                send_id;
    wbuf_pkg::wbuf_id_t                head_id;
    wbuf_pkg::wbuf_tag_t               head_tag;

    wbuf_cfg_regs u_cfg (
        .clk_i, .rst_ni, .cfg_valid_i, .cfg_sel_i, .cfg_wdata_i,
        .threshold_o          (threshold),
        .reset_on_write_o     (reset_on_write),
        .inhibit_coalescing_o (inhibit_coalescing)
    );

    wbuf_dir u_dir (
        .clk_i, .rst_ni, .write_valid_i, .write_ready_o, .write_addr_i,
        .flush_all_i, .read_addr_i, .read_hit_o, .empty_o, .full_o,
        .threshold_i          (threshold),
        .reset_on_write_i     (reset_on_write),
        .inhibit_coalescing_i (inhibit_coalescing),
        .store_we_o           (store_we),
        .store_init_o         (store_init),
        .store_id_o           (store_id),
        .pend_o               (pend),
        .send_fire_i          (send_fire),
        .send_id_i            (send_id),
        .ack_valid_i          (mem_ack_valid_i),
        .ack_id_i             (mem_ack_id_i),
        .head_id_i            (head_id),
        .head_tag_o           (head_tag)
    );

    // Word select comes straight from the write address
    wbuf_line_store u_store (
        .clk_i, .rst_ni,
        .we_i       (store_we),
        .init_i     (store_init),
        .id_i       (store_id),
        .word_sel_i (write_addr_i[wbuf_pkg::OFFSET_WIDTH-1:wbuf_pkg::WORD_OFFSET_WIDTH]),
        .data_i     (write_data_i),
        .be_i       (write_be_i),
        .rd_id_i    (head_id),
        .rd_data_o  (mem_req_data_o),
        .rd_be_o    (mem_req_be_o)
    );

    wbuf_send u_send (
        .clk_i, .rst_ni,
        .pend_i      (pend),
        .send_fire_o (send_fire),
        .send_id_o   (send_id),
        .req_valid_o (mem_req_valid_o),
        .req_ready_i (mem_req_ready_i),
        .head_id_o   (head_id)
    );

    // Whole line request, so the offset is always zero
    assign mem_req_addr_o = {head_tag, {wbuf_pkg::OFFSET_WIDTH{1'b0}}};
    assign mem_req_id_o   = head_id;

endmodule

// ==== testbench/tb_wbuf.sv ====
//------------------------------------------------------------
// Coalescing write buffer testbench
// Directed tests with a line model, a request responder,
// typed compare tasks and a cycle timeout
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_wbuf;

    // All tests together take a few hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic                    clk_i           = 1'b0;
    logic                    rst_ni          = 1'b0;
    logic                    write_valid_i   = 1'b0;
    logic                    write_ready_o;
    wbuf_pkg::wbuf_addr_t    write_addr_i    = '0;
    wbuf_pkg::wbuf_word_t    write_data_i    = '0;
    wbuf_pkg::wbuf_word_be_t write_be_i      = '0;
    logic                    cfg_valid_i     = 1'b0;
    wbuf_pkg::wbuf_cfg_reg_e cfg_sel_i       = wbuf_pkg::CFG_THRESHOLD;
    wbuf_pkg::wbuf_timecnt_t cfg_wdata_i     = '0;
    logic                    flush_all_i     = 1'b0;
    wbuf_pkg::wbuf_addr_t    read_addr_i     = '0;
    logic                    read_hit_o;
    logic                    empty_o;
    logic                    full_o;
    logic                    mem_req_valid_o;
    logic                    mem_req_ready_i = 1'b0;
    wbuf_pkg::wbuf_addr_t    mem_req_addr_o;
    wbuf_pkg::wbuf_line_t    mem_req_data_o;
    wbuf_pkg::wbuf_line_be_t mem_req_be_o;
    wbuf_pkg::wbuf_id_t      mem_req_id_o;
    logic                    mem_ack_valid_i = 1'b0;
    wbuf_pkg::wbuf_id_t      mem_ack_id_i    = '0;

    // Line under construction and the lines memory should receive
    wbuf_pkg::wbuf_line_t    mdl_data = '0;
    wbuf_pkg::wbuf_line_be_t mdl_be   = '0;
    wbuf_pkg::wbuf_addr_t    exp_addr [$];
    wbuf_pkg::wbuf_line_t    exp_data [$];
    wbuf_pkg::wbuf_line_be_t exp_be   [$];
    wbuf_pkg::wbuf_id_t      exp_id   [$];
    int                      seed     = 32'h165935e7;
    int                      cycles   = 0;

    wbuf_top u_dut (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            abort_run($sformatf("Timeout: tests still running after %0d cycles", cycles));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_addr(input string n, input wbuf_pkg::wbuf_addr_t got, exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h", $time, n, got, exp));
    endtask

    task automatic check_line(input string n, input wbuf_pkg::wbuf_line_t got, exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h", $time, n, got, exp));
    endtask

    task automatic check_be(input string n, input wbuf_pkg::wbuf_line_be_t got, exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h", $time, n, got, exp));
    endtask

    task automatic check_id(input string n, input wbuf_pkg::wbuf_id_t got, exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s = %0d, expected %0d", $time, n, got, exp));
    endtask

    task automatic check_bit(input string n, input logic got, exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s = %b, expected %b", $time, n, got, exp));
    endtask

    // Random word merged into the model line, held until the DUT takes it
    task automatic drive_write(input wbuf_pkg::wbuf_addr_t a, input wbuf_pkg::wbuf_word_be_t be);
        wbuf_pkg::wbuf_word_t d;
        int                   w;
        d = wbuf_pkg::wbuf_word_t'($random(seed));
        w = int'(a[3:2]);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                mdl_data[w*32 + b*8 +: 8] = d[b*8 +: 8];
                mdl_be[w*4 + b]           = 1'b1;
            end
        end
        write_valid_i = 1'b1;
        write_addr_i  = a;
        write_data_i  = d;
        write_be_i    = be;
        #1;
        while (!write_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        write_valid_i = 1'b0;
    endtask

    // New lines take the lowest free entry
    task automatic expect_line(input wbuf_pkg::wbuf_addr_t a, input wbuf_pkg::wbuf_id_t id);
        exp_addr.push_back({a[31:4], 4'h0});
        exp_data.push_back(mdl_data);
        exp_be.push_back(mdl_be);
        exp_id.push_back(id);
        mdl_be = '0;
    endtask

    task automatic write_cfg(input wbuf_pkg::wbuf_cfg_reg_e sel, input wbuf_pkg::wbuf_timecnt_t v);
        cfg_valid_i = 1'b1;
        cfg_sel_i   = sel;
        cfg_wdata_i = v;
        @(negedge clk_i);
        cfg_valid_i = 1'b0;
    endtask

    task automatic pulse_flush();
        flush_all_i = 1'b1;
        @(negedge clk_i);
        flush_all_i = 1'b0;
    endtask

    // Accept the head request, match it to an expected line by entry id, acknowledge later
    task automatic serve_request();
        wbuf_pkg::wbuf_line_t data;
        wbuf_pkg::wbuf_id_t   id;
        int                   idx;
        idx = -1;
        while (!mem_req_valid_o)
            @(negedge clk_i);
        for (int i = exp_id.size() - 1; i >= 0; i--) begin
            if (exp_id[i] == mem_req_id_o)
                idx = i;
        end
        if (idx < 0)
            abort_run($sformatf("Request with id %0d that no test expects", mem_req_id_o));
        // Bytes never written hold stale data
        data = mem_req_data_o;
        for (int b = 0; b < 16; b++) begin
            if (!exp_be[idx][b])
                data[b*8 +: 8] = exp_data[idx][b*8 +: 8];
        end
        check_addr("mem_req_addr_o", mem_req_addr_o, exp_addr[idx]);
        check_be("mem_req_be_o", mem_req_be_o, exp_be[idx]);
        check_line("mem_req_data_o", data, exp_data[idx]);
        id = mem_req_id_o;
        exp_addr.delete(idx);
        exp_data.delete(idx);
        exp_be.delete(idx);
        exp_id.delete(idx);
        mem_req_ready_i = 1'b1;
        @(negedge clk_i);
        mem_req_ready_i = 1'b0;
        repeat (3) @(negedge clk_i);
        mem_ack_valid_i = 1'b1;
        mem_ack_id_i    = id;
        @(negedge clk_i);
        mem_ack_valid_i = 1'b0;
    endtask

    task automatic single_write();
        drive_write(32'h0000_1008, 4'b1011);
        expect_line(32'h0000_1008, 2'd0);
        while (!mem_req_valid_o)
            @(negedge clk_i);
        check_id("mem_req_id_o", mem_req_id_o, 2'd0);
        serve_request();
        check_bit("empty_o", empty_o, 1'b1);
        check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    endtask

    // Third write lands on bytes of the first word
    task automatic coalesce_line();
        write_cfg(wbuf_pkg::CFG_THRESHOLD, 8'd20);
        drive_write(32'h0000_2000, 4'b1111);
        drive_write(32'h0000_2008, 4'b0011);
        drive_write(32'h0000_2000, 4'b0110);
        expect_line(32'h0000_2000, 2'd0);
        serve_request();
        check_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic inhibit_merge();
        write_cfg(wbuf_pkg::CFG_CTRL, 8'h02);
        drive_write(32'h0000_3004, 4'b1100);
        expect_line(32'h0000_3004, 2'd0);
        drive_write(32'h0000_300c, 4'b0001);
        expect_line(32'h0000_300c, 2'd1);
        serve_request();
        serve_request();
        check_bit("empty_o", empty_o, 1'b1);
        write_cfg(wbuf_pkg::CFG_CTRL, 8'h00);
    endtask

    task automatic flush_open_entries();
        write_cfg(wbuf_pkg::CFG_THRESHOLD, 8'd255);
        drive_write(32'h0000_4010, 4'b1111);
        expect_line(32'h0000_4010, 2'd0);
        pulse_flush();
        // Pending after one edge, queued after the next
        repeat (3) @(negedge clk_i);
        check_bit("mem_req_valid_o", mem_req_valid_o, 1'b1);
        serve_request();
    endtask

    task automatic read_hit_lookup();
        drive_write(32'h0000_5000, 4'b0001);
        expect_line(32'h0000_5000, 2'd0);
        read_addr_i = 32'h0000_500c;
        #1;
        check_bit("read_hit_o", read_hit_o, 1'b1);
        @(negedge clk_i);
        read_addr_i = 32'h0000_6000;
        #1;
        check_bit("read_hit_o", read_hit_o, 1'b0);
        @(negedge clk_i);
        read_addr_i = 32'h0000_500c;
        pulse_flush();
        serve_request();
        check_bit("read_hit_o", read_hit_o, 1'b0);
    endtask

    task automatic back_pressure();
        wbuf_pkg::wbuf_addr_t a;
        write_cfg(wbuf_pkg::CFG_THRESHOLD, 8'd0);
        for (int i = 0; i < 4; i++) begin
            a = wbuf_pkg::wbuf_addr_t'(32'h0001_0000 + i * 256);
            drive_write(a, 4'b1111);
            expect_line(a, wbuf_pkg::wbuf_id_t'(i));
        end
        check_bit("full_o", full_o, 1'b1);
        write_valid_i = 1'b1;
        write_addr_i  = 32'h0001_0400;
        #1;
        check_bit("write_ready_o", write_ready_o, 1'b0);
        @(negedge clk_i);
        write_valid_i = 1'b0;
        // Lines leave in round-robin order, matched by entry id
        for (int i = 0; i < 4; i++)
            serve_request();
        check_bit("empty_o", empty_o, 1'b1);
    endtask

    initial begin
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        check_bit("write_ready_o", write_ready_o, 1'b1);
        check_bit("empty_o", empty_o, 1'b1);
        check_bit("full_o", full_o, 1'b0);
        check_bit("read_hit_o", read_hit_o, 1'b0);
        check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
        single_write();
        coalesce_line();
        inhibit_merge();
        flush_open_entries();
        read_hit_lookup();
        back_pressure();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/wbuf_pkg.sv
rtl/wbuf_cfg_regs.sv
rtl/wbuf_dir.sv
rtl/wbuf_line_store.sv
rtl/wbuf_send.sv
rtl/wbuf_top.sv
testbench/tb_wbuf.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_wbuf
FILELIST = verilog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
